//--- rv_exec_core.f
+incdir+include
design/rv_pkg.sv
design/rv_reg_name.sv
design/rv_operand_extract.sv
design/rv_decode.sv
design/rv_regfile.sv
design/rv_execute.sv
design/rv_exec_core.sv
bench/tb_clock_gen.sv
bench/rv_exec_core_assert.sv
bench/rv_exec_core_tb.sv

//--- bench/rv_exec_core_tb.sv
`timescale 1ns/1ns
`include "rv_opcodes.svh"

module rv_exec_core_tb import rv_pkg::*; ();

  localparam int INSTR_BUDGET = 400;
  localparam int MAX_CYCLES   = INSTR_BUDGET * 5; // Room for drains and idle gaps

  typedef struct packed {
    result_t r;
    logic    chk_target;
    logic    chk_store;
  } expect_t;

  logic    clk;
  logic    rst;
  logic    instr_valid;
  word_t   instr;
  word_t   pc;
  result_t result;

  word_t   shadow [32]; // Architectural register model
  word_t   pc_next;
  expect_t expect_q [$];
  int      mismatches = 0;
  int      failures   = 0;
  int      cycles     = 0;

  tb_clock_gen #(.PERIOD_NS(8)) i_tb_clock_gen (.clk(clk));

  rv_exec_core #(.REG_COUNT(32)) i_rv_exec_core (
    .clk        (clk),
    .rst        (rst),
    .instr_valid(instr_valid),
    .instr      (instr),
    .pc         (pc),
    .result     (result)
  );

  bind rv_exec_core rv_exec_core_assert i_rv_exec_core_assert (.*);

  task automatic check_word(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("Mismatch %s at pc %h: got %h, expected %h", what, result.pc, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_idx(input string what, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp) begin
      $display("Mismatch %s at pc %h: got %h, expected %h", what, result.pc, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_name(input string what, input reg_name_t got, input reg_name_t exp);
    if (got !== exp) begin
      $display("Mismatch %s at pc %h: got %h, expected %h", what, result.pc, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch %s at pc %h: got %h, expected %h", what, result.pc, got, exp);
      mismatches++;
    end
  endtask

  // ABI name built from the register groups of the calling convention
  function automatic reg_name_t abi_name(input int n);
    byte pfx;
    int  k;
    if (n == 0) return "zero";
    if (n < 5) return (n == 1) ? "ra  " : (n == 2) ? "sp  " : (n == 3) ? "gp  " : "tp  ";
    if (n < 8) begin
      pfx = "t";
      k   = n - 5;
    end else if (n < 10) begin
      pfx = "s";
      k   = n - 8;
    end else if (n < 18) begin
      pfx = "a";
      k   = n - 10;
    end else if (n < 28) begin
      pfx = "s";
      k   = n - 16;
    end else begin
      pfx = "t";
      k   = n - 25;
    end
    if (k < 10) return {pfx, 8'(48 + k), "  "};
    return {pfx, "1", 8'(38 + k), " "};
  endfunction

  function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                    input word_t a, input word_t b);
    case (f3)
      `F3_ADD_SUB: return alt ? a - b : a + b;
      `F3_SLL:     return a << b[4:0];
      `F3_SLT:     return word_t'($signed(a) < $signed(b));
      `F3_SLTU:    return word_t'(a < b);
      `F3_XOR:     return a ^ b;
      `F3_SRL_SRA: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      `F3_OR:      return a | b;
      default:     return a & b;
    endcase
  endfunction

  function automatic logic branch_ref(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
      `F3_BEQ:  return a == b;
      `F3_BNE:  return a != b;
      `F3_BLT:  return $signed(a) < $signed(b);
      `F3_BGE:  return $signed(a) >= $signed(b);
      `F3_BLTU: return a < b;
      default:  return a >= b;
    endcase
  endfunction

  // Expected result in program order, updates the register model
  function automatic result_t model_exec(input word_t ins, input word_t at_pc);
    result_t r;
    word_t   a;
    word_t   b;
    word_t   i_imm;
    logic    writes;
    r          = '0;
    a          = shadow[ins[19:15]];
    b          = shadow[ins[24:20]];
    i_imm      = {{20{ins[31]}}, ins[31:20]};
    writes     = 1'b1;
    r.valid    = 1'b1;
    r.pc       = at_pc;
    r.rd       = ins[11:7];
    r.rd_name  = abi_name(ins[11:7]);
    r.rs1_name = abi_name(ins[19:15]);
    r.rs2_name = abi_name(ins[24:20]);
    case (ins[6:0])
      `OPC_OP:     r.data = alu_ref(ins[14:12], ins[30], a, b);
      `OPC_OP_IMM: r.data = alu_ref(ins[14:12], ins[14:12] == `F3_SRL_SRA && ins[30], a, i_imm);
      `OPC_LUI:    r.data = {ins[31:12], 12'h000};
      `OPC_AUIPC:  r.data = at_pc + {ins[31:12], 12'h000};
      `OPC_JAL: begin
        r.data     = at_pc + 4;
        r.br_taken = 1'b1;
        r.target   = at_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      `OPC_JALR: begin
        r.data     = at_pc + 4;
        r.br_taken = 1'b1;
        r.target   = (a + i_imm) & ~32'd1;
      end
      `OPC_BRANCH: begin
        writes     = 1'b0;
        r.br_taken = branch_ref(ins[14:12], a, b);
        r.target   = at_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      end
      `OPC_STORE: begin
        writes       = 1'b0;
        r.store_addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
        r.store_data = b;
      end
      `OPC_MISC_MEM, `OPC_SYSTEM: writes = 1'b0;
      default: begin
        writes    = 1'b0;
        r.illegal = 1'b1;
      end
    endcase
    r.wr_en = writes && r.rd != '0;
    if (r.wr_en) shadow[r.rd] = r.data;
    return r;
  endfunction

  function automatic word_t enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                  input reg_idx_t rd, input reg_idx_t rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t enc_s(input reg_idx_t rs1, input reg_idx_t rs2, input logic [11:0] off);
    return {off[11:5], rs2, rs1, 3'b010, off[4:0], `OPC_STORE};
  endfunction

  function automatic word_t enc_b(input logic [2:0] f3, input reg_idx_t rs1,
                                  input reg_idx_t rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OPC_BRANCH};
  endfunction

  function automatic word_t enc_j(input reg_idx_t rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, `OPC_JAL};
  endfunction

  // Called on a falling edge, returns on the next one
  task automatic issue(input word_t ins);
    expect_t e;
    instr_valid  = 1'b1;
    instr        = ins;
    pc           = pc_next;
    e.r          = model_exec(ins, pc_next);
    e.chk_target = ins[6:0] inside {`OPC_JAL, `OPC_JALR, `OPC_BRANCH};
    e.chk_store  = ins[6:0] == `OPC_STORE;
    expect_q.push_back(e);
    pc_next += 4;
    @(negedge clk);
    instr_valid = 1'b0;
  endtask

  task automatic load_reg(input reg_idx_t rd, input word_t v);
    word_t up;
    up = v + 32'h800; // ADDI sign-extends the low part
    issue({up[31:12], rd, `OPC_LUI});
    issue(enc_i(`OPC_OP_IMM, `F3_ADD_SUB, rd, rd, v[11:0]));
  endtask

  task automatic drain();
    while (expect_q.size() != 0) @(negedge clk);
  endtask

  task automatic test_alu();
    word_t a;
    word_t b;
    for (int round = 0; round < 6; round++) begin
      a = (round == 0) ? 32'hffff_fff0 : $urandom;
      b = (round == 0) ? 32'h0000_0010 : $urandom;
      load_reg(5'd5, a);
      load_reg(5'd6, b);
      for (int f3 = 0; f3 < 8; f3++) begin
        issue(enc_i(`OPC_OP, 3'(f3), 5'd7, 5'd5, {7'h00, 5'd6}));
        if (f3 == 0 || f3 == 5) issue(enc_i(`OPC_OP, 3'(f3), 5'd7, 5'd5, {7'h20, 5'd6}));
        if (f3 == 1 || f3 == 5) begin // Shift amount only, bit 30 picks SRAI
          issue(enc_i(`OPC_OP_IMM, 3'(f3), 5'd7, 5'd5, {7'h00, b[4:0]}));
          if (f3 == 5) issue(enc_i(`OPC_OP_IMM, 3'(f3), 5'd7, 5'd5, {7'h20, b[4:0]}));
        end else begin
          issue(enc_i(`OPC_OP_IMM, 3'(f3), 5'd7, 5'd5, b[11:0]));
        end
      end
    end
    drain();
  endtask

  task automatic test_imm();
    issue(enc_i(`OPC_OP_IMM, `F3_ADD_SUB, 5'd8, 5'd0, 12'hffb));
    issue(enc_i(`OPC_OP_IMM, `F3_ADD_SUB, 5'd9, 5'd0, 12'h7ff));
    issue(enc_i(`OPC_OP_IMM, `F3_ADD_SUB, 5'd10, 5'd9, 12'h800));
    issue(enc_s(5'd8, 5'd9, 12'hff8));
    issue(enc_s(5'd9, 5'd8, 12'h3f4));
    issue(enc_b(`F3_BNE, 5'd8, 5'd9, 13'h1ff0)); // Backward
    issue(enc_b(`F3_BEQ, 5'd8, 5'd9, 13'h0ffe));
    issue(enc_j(5'd1, 21'h1f_f800));
    issue(enc_j(5'd1, 21'h0f_fffe));
    issue({20'h80000, 5'd11, `OPC_LUI});
    issue({20'h12345, 5'd12, `OPC_AUIPC});
    issue({20'hfffff, 5'd13, `OPC_AUIPC});
    drain();
  endtask

  task automatic branch_pair(input word_t a, input word_t b);
    word_t off;
    load_reg(5'd14, a);
    load_reg(5'd15, b);
    for (int f3 = 0; f3 < 8; f3++) begin
      off = $urandom;
      if (f3 != 2 && f3 != 3) issue(enc_b(3'(f3), 5'd14, 5'd15, {off[11:0], 1'b0}));
    end
  endtask

  task automatic test_branch();
    branch_pair(32'd5, 32'd5);
    branch_pair(32'hffff_fffd, 32'd7);
    branch_pair(32'd9, 32'hffff_fffe);
    load_reg(5'd16, 32'h0000_1001);
    issue(enc_j(5'd1, 21'h00_0100));
    issue(enc_i(`OPC_JALR, 3'b000, 5'd1, 5'd16, 12'h002)); // Odd sum
    issue(enc_i(`OPC_JALR, 3'b000, 5'd0, 5'd16, 12'hff0));
    issue(enc_i(`OPC_OP, `F3_ADD_SUB, 5'd17, 5'd1, 12'h000));
    drain();
  endtask

  task automatic test_forward();
    issue(enc_i(`OPC_OP_IMM, `F3_ADD_SUB, 5'd20, 5'd0, 12'h123));
    repeat (4) issue(enc_i(`OPC_OP, `F3_ADD_SUB, 5'd20, 5'd20, {7'h00, 5'd20}));
    issue(enc_i(`OPC_OP, `F3_ADD_SUB, 5'd21, 5'd20, {7'h20, 5'd20}));
    issue(enc_i(`OPC_OP_IMM, `F3_XOR, 5'd22, 5'd20, 12'hfff));
    issue(enc_s(5'd20, 5'd22, 12'h010));
    issue(enc_b(`F3_BNE, 5'd22, 5'd20, 13'h0040));
    issue(enc_i(`OPC_JALR, 3'b000, 5'd23, 5'd22, 12'h004));
    issue(enc_i(`OPC_OP, `F3_ADD_SUB, 5'd24, 5'd23, {7'h00, 5'd22}));
    drain();
  endtask

  task automatic test_no_write();
    load_reg(5'd5, 32'hcafe_f00d);
    issue(enc_i(`OPC_OP_IMM, `F3_ADD_SUB, 5'd0, 5'd5, 12'h321));
    issue({20'habcde, 5'd0, `OPC_LUI});
    issue(32'h0000_0073); // ECALL
    issue(32'h0010_0073); // EBREAK
    issue(enc_i(`OPC_SYSTEM, 3'b001, 5'd5, 5'd6, 12'h300)); // CSRRW
    issue(32'h0ff0_000f); // FENCE
    issue(enc_i(`OPC_LOAD, 3'b010, 5'd5, 5'd6, 12'h000));
    repeat (3) @(negedge clk);
    issue(enc_i(`OPC_OP, `F3_ADD_SUB, 5'd25, 5'd0, {7'h00, 5'd5}));
    issue(enc_i(`OPC_OP, `F3_ADD_SUB, 5'd26, 5'd0, {7'h00, 5'd0}));
    drain();
  endtask

  task automatic test_names();
    word_t r;
    repeat (16) begin
      r = $urandom;
      issue(enc_i(`OPC_OP, `F3_ADD_SUB, r[4:0], r[9:5], {7'h00, r[14:10]}));
    end
    drain();
  endtask

  // Results are stable on the falling edge
  always @(negedge clk) begin
    expect_t e;
    if (!rst && result.valid) begin
      if (expect_q.size() == 0) begin
        $display("Result at pc %h arrived with no instruction outstanding", result.pc);
        failures++;
      end else begin
        e = expect_q.pop_front();
        check_word("pc", result.pc, e.r.pc);
        check_idx("rd", result.rd, e.r.rd);
        check_flag("wr_en", result.wr_en, e.r.wr_en);
        if (e.r.wr_en) check_word("data", result.data, e.r.data);
        check_flag("br_taken", result.br_taken, e.r.br_taken);
        if (e.chk_target) check_word("target", result.target, e.r.target);
        if (e.chk_store) check_word("store_addr", result.store_addr, e.r.store_addr);
        if (e.chk_store) check_word("store_data", result.store_data, e.r.store_data);
        check_flag("illegal", result.illegal, e.r.illegal);
        check_name("rd_name", result.rd_name, e.r.rd_name);
        check_name("rs1_name", result.rs1_name, e.r.rs1_name);
        check_name("rs2_name", result.rs2_name, e.r.rs2_name);
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("Timeout after %0d cycles with %0d results outstanding", cycles, expect_q.size());
      $display("TEST FAIL");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'h9b99_140d));
    rst         = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    pc          = '0;
    pc_next     = 32'h0000_1000;
    foreach (shadow[i]) shadow[i] = '0;
    repeat (5) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    test_alu();
    test_imm();
    test_branch();
    test_forward();
    test_no_write();
    test_names();
    repeat (4) @(negedge clk);
    failures += i_rv_exec_core.i_rv_exec_core_assert.fails;
    $display("Run complete: %0d mismatches, %0d other errors", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- bench/rv_exec_core_assert.sv
`timescale 1ns/1ns

module rv_exec_core_assert import rv_pkg::*; (
  input logic    clk,
  input logic    rst,
  input logic    instr_valid,
  input logic    rf_wr_en,
  input result_t result
);

  int fails = 0; // Failed assertion count

  // Issue to result latency is two cycles in both directions
  a_lat_fwd: assert property (@(posedge clk) disable iff (rst)
    instr_valid |-> ##2 result.valid)
    else begin
      fails++;
      $error("result.valid did not follow instr_valid after two cycles");
    end

  a_lat_back: assert property (@(posedge clk) disable iff (rst)
    result.valid |-> $past(instr_valid, 2))
    else begin
      fails++;
      $error("result.valid without an instruction two cycles before");
    end

  a_no_x0_write: assert property (@(posedge clk) disable iff (rst)
    (result.valid && result.rd == '0) |-> (!result.wr_en && !rf_wr_en))
    else begin
      fails++;
      $error("register write requested for x0");
    end

  a_rst_quiet: assert property (@(posedge clk)
    rst |=> !result.valid)
    else begin
      fails++;
      $error("result.valid high during reset");
    end

  a_rst_exit: assert property (@(posedge clk)
    $fell(rst) |-> !result.valid ##1 !result.valid)
    else begin
      fails++;
      $error("result.valid high within two cycles of reset release");
    end

endmodule

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int PERIOD_NS = 8
) (
  output logic clk
);

  initial clk = 1'b0;

  always #(PERIOD_NS / 2) clk = ~clk;

endmodule

//--- design/rv_exec_core.sv
`timescale 1ns/1ns

module rv_exec_core import rv_pkg::*; #(
  parameter int REG_COUNT = 32 // 16 for RV32E
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    instr_valid,
  input  word_t   instr,
  input  word_t   pc,
  output result_t result
);

  decoded_t dec;
  reg_idx_t ra1;
  reg_idx_t ra2;
  word_t    rd1;
  word_t    rd2;
  logic     rf_wr_en;

  rv_decode i_rv_decode (
    .clk        (clk),
    .rst        (rst),
    .instr_valid(instr_valid),
    .instr      (instr),
    .pc         (pc),
    .dec        (dec)
  );

  rv_execute #(
    .REG_COUNT(REG_COUNT)
  ) i_rv_execute (
    .clk(clk),
    .rst(rst),
    .dec(dec),
    .ra1(ra1),
    .ra2(ra2),
    .rd1(rd1),
    .rd2(rd2),
    .res(result)
  );

  // Write back one edge after the result shows up
  assign rf_wr_en = result.valid & result.wr_en;

  rv_regfile #(
    .REG_COUNT(REG_COUNT)
  ) i_rv_regfile (
    .clk  (clk),
    .rst  (rst),
    .ra1  (ra1),
    .ra2  (ra2),
    .rd1  (rd1),
    .rd2  (rd2),
    .wr_en(rf_wr_en),
    .wa   (result.rd),
    .wd   (result.data)
  );

endmodule

//--- design/rv_execute.sv
`timescale 1ns/1ns

module rv_execute import rv_pkg::*; #(
  parameter int REG_COUNT = 32
) (
  input  logic     clk,
  input  logic     rst,
  input  decoded_t dec,
  output reg_idx_t ra1,
  output reg_idx_t ra2,
  input  word_t    rd1,
  input  word_t    rd2,
  output result_t  res
);

  word_t   a_fwd;
  word_t   b_fwd;
  word_t   op_a;
  word_t   op_b;
  word_t   alu_y;
  word_t   tgt_base;
  word_t   tgt_sum;
  logic    is_branch;
  logic    is_jalr;
  logic    br_cond;
  logic    reg_ok;
  result_t res_next;

  assign ra1 = dec.rs1;
  assign ra2 = dec.rs2;

  // Result still in flight has priority over the register file
  assign a_fwd = (res.valid && res.wr_en && res.rd == dec.rs1) ? res.data : rd1;
  assign b_fwd = (res.valid && res.wr_en && res.rd == dec.rs2) ? res.data : rd2;

  assign op_a = (dec.instr_type == TYPE_U || dec.instr_type == TYPE_UJ) ? dec.pc : a_fwd;
  assign op_b = dec.flags[`FLAG_USES_RS2] ? b_fwd : dec.imm;

  always_comb begin
    case (dec.alu_op)
      ALU_ADD:    alu_y = op_a + op_b;
      ALU_SUB:    alu_y = op_a - op_b;
      ALU_SLL:    alu_y = op_a << op_b[4:0];
      ALU_SLT:    alu_y = {31'd0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   alu_y = {31'd0, op_a < op_b};
      ALU_XOR:    alu_y = op_a ^ op_b;
      ALU_SRL:    alu_y = op_a >> op_b[4:0];
      ALU_SRA:    alu_y = word_t'($signed(op_a) >>> op_b[4:0]);
      ALU_OR:     alu_y = op_a | op_b;
      ALU_AND:    alu_y = op_a & op_b;
      ALU_PASS_B: alu_y = op_b;
      ALU_PC_ADD: alu_y = dec.pc + 32'd4;
      default:    alu_y = '0;
    endcase
  end

  always_comb begin
    case (dec.funct3)
      `F3_BEQ:  br_cond = a_fwd == b_fwd;
      `F3_BNE:  br_cond = a_fwd != b_fwd;
      `F3_BLT:  br_cond = $signed(a_fwd) < $signed(b_fwd);
      `F3_BGE:  br_cond = $signed(a_fwd) >= $signed(b_fwd);
      `F3_BLTU: br_cond = a_fwd < b_fwd;
      `F3_BGEU: br_cond = a_fwd >= b_fwd;
      default:  br_cond = 1'b0;
    endcase
  end

  assign is_branch = dec.instr_type == TYPE_SB;
  assign is_jalr   = dec.flags[`FLAG_IS_CTRL] && dec.instr_type == TYPE_I;

  // JAL has pc in op_a, JALR has rs1
  assign tgt_base = is_branch ? dec.pc : op_a;
  assign tgt_sum  = tgt_base + dec.imm;

  // RV32E style check on the register numbers actually used
  assign reg_ok = (!dec.flags[`FLAG_USES_RD]  || int'(dec.rd)  < REG_COUNT) &&
                  (!dec.flags[`FLAG_USES_RS1] || int'(dec.rs1) < REG_COUNT) &&
                  (!dec.flags[`FLAG_USES_RS2] || int'(dec.rs2) < REG_COUNT);

  always_comb begin
    res_next.valid      = dec.valid;
    res_next.pc         = dec.pc;
    res_next.rd         = dec.rd;
    res_next.wr_en      = dec.flags[`FLAG_USES_RD] && dec.rd != '0;
    res_next.data       = alu_y;
    res_next.br_taken   = dec.flags[`FLAG_IS_CTRL] && (!is_branch || br_cond);
    res_next.target     = dec.flags[`FLAG_IS_CTRL] ? {tgt_sum[31:1], tgt_sum[0] & ~is_jalr} : '0;
    res_next.store_addr = dec.flags[`FLAG_IS_STORE] ? a_fwd + dec.imm : '0;
    res_next.store_data = dec.flags[`FLAG_IS_STORE] ? b_fwd : '0;
    res_next.illegal    = (dec.instr_type == TYPE_NONE && dec.flags[`FLAG_IS_DIFF]) || !reg_ok;
    res_next.rd_name    = dec.rd_name;
    res_next.rs1_name   = dec.rs1_name;
    res_next.rs2_name   = dec.rs2_name;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res.valid <= 1'b0;
    end else begin
      res <= res_next;
    end
  end

endmodule

//--- design/rv_regfile.sv
`timescale 1ns/1ns

module rv_regfile import rv_pkg::*; #(
  parameter int REG_COUNT = 32
) (
  input  logic     clk,
  input  logic     rst,
  input  reg_idx_t ra1,
  input  reg_idx_t ra2,
  output word_t    rd1,
  output word_t    rd2,
  input  logic     wr_en,
  input  reg_idx_t wa,
  input  word_t    wd
);

  word_t regs [REG_COUNT];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wa != '0 && int'(wa) < REG_COUNT) begin
      regs[wa] <= wd;
    end
  end

  // x0 and registers past REG_COUNT read as zero
  assign rd1 = (ra1 != '0 && int'(ra1) < REG_COUNT) ? regs[ra1] : '0;
  assign rd2 = (ra2 != '0 && int'(ra2) < REG_COUNT) ? regs[ra2] : '0;

endmodule

//--- design/rv_decode.sv
`timescale 1ns/1ns

module rv_decode import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     instr_valid,
  input  word_t    instr,
  input  word_t    pc,
  output decoded_t dec
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  instr_type_t itype;
  alu_op_t     alu_op;
  flag_t       in_flag;
  decoded_t    dec_next;

  function automatic alu_op_t alu_from_f3(input logic [2:0] f3, input logic alt);
    alu_op_t op;
    case (f3)
      `F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
      `F3_SLL:     op = ALU_SLL;
      `F3_SLT:     op = ALU_SLT;
      `F3_SLTU:    op = ALU_SLTU;
      `F3_XOR:     op = ALU_XOR;
      `F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
      `F3_OR:      op = ALU_OR;
      default:     op = ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];

  always_comb begin
    itype   = TYPE_NONE;
    alu_op  = ALU_ADD;
    in_flag = '0;
    in_flag[`FLAG_IS_SIGNED] = 1'b1;
    case (opcode)
      `OPC_OP: begin
        itype  = TYPE_R;
        alu_op = alu_from_f3(funct3, instr[30]);
      end
      `OPC_OP_IMM: begin
        itype  = TYPE_I;
        alu_op = alu_from_f3(funct3, (funct3 == `F3_SRL_SRA) && instr[30]); // No SUBI
      end
      `OPC_LUI: begin
        itype  = TYPE_U;
        alu_op = ALU_PASS_B;
      end
      `OPC_AUIPC: itype = TYPE_U; // Adds to pc in execute
      `OPC_JAL: begin
        itype  = TYPE_UJ;
        alu_op = ALU_PC_ADD;
        in_flag[`FLAG_IS_CTRL] = 1'b1;
      end
      `OPC_JALR: begin
        itype  = TYPE_I;
        alu_op = ALU_PC_ADD;
        in_flag[`FLAG_IS_CTRL] = 1'b1;
      end
      `OPC_BRANCH: begin
        itype  = TYPE_SB;
        alu_op = ALU_SUB;
        in_flag[`FLAG_IS_CTRL] = 1'b1;
      end
      `OPC_STORE: begin
        itype = TYPE_S;
        in_flag[`FLAG_IS_STORE] = 1'b1;
      end
      `OPC_MISC_MEM, `OPC_SYSTEM: begin
        itype        = TYPE_I;
        in_flag[3:0] = 4'b1110; // Retire with no register write
        in_flag[`FLAG_IS_DIFF] = 1'b1;
      end
      default: begin // Loads and unknown opcodes
        in_flag[`FLAG_IS_DIFF]   = 1'b1;
        in_flag[`FLAG_IS_SIGNED] = 1'b0;
      end
    endcase
  end

  rv_operand_extract i_rv_operand_extract (
    .instr     (instr),
    .instr_type(itype),
    .in_flag   (in_flag),
    .rd        (dec_next.rd),
    .rs1       (dec_next.rs1),
    .rs2       (dec_next.rs2),
    .rd_name   (dec_next.rd_name),
    .rs1_name  (dec_next.rs1_name),
    .rs2_name  (dec_next.rs2_name),
    .imm       (dec_next.imm),
    .flag      (dec_next.flags)
  );

  assign dec_next.valid      = instr_valid;
  assign dec_next.pc         = pc;
  assign dec_next.instr_type = itype;
  assign dec_next.alu_op     = alu_op;
  assign dec_next.funct3     = funct3;

  always_ff @(posedge clk) begin
    if (rst) begin
      dec.valid <= 1'b0;
    end else begin
      dec <= dec_next;
    end
  end

endmodule

//--- design/rv_operand_extract.sv
`timescale 1ns/1ns

module rv_operand_extract import rv_pkg::*; (
  input  word_t       instr,
  input  instr_type_t instr_type,
  input  flag_t       in_flag,
  output reg_idx_t    rd,
  output reg_idx_t    rs1,
  output reg_idx_t    rs2,
  output reg_name_t   rd_name,
  output reg_name_t   rs1_name,
  output reg_name_t   rs2_name,
  output word_t       imm,
  output flag_t       flag
);

  logic       sx;    // Sign fill bit
  logic [3:0] uses;

  assign rd  = instr[11:7];
  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];

  rv_reg_name i_rd_name  (.reg_number(rd),  .reg_name(rd_name));
  rv_reg_name i_rs1_name (.reg_number(rs1), .reg_name(rs1_name));
  rv_reg_name i_rs2_name (.reg_number(rs2), .reg_name(rs2_name));

  // Bit 31 is the top immediate bit for every format
  assign sx = instr[31] & in_flag[`FLAG_IS_SIGNED];

  always_comb begin
    case (instr_type)
      TYPE_R: begin
        uses = 4'b0111;
        imm  = '0;
      end
      TYPE_I: begin
        uses = 4'b1011;
        imm  = {{20{sx}}, instr[31:20]};
      end
      TYPE_S: begin
        uses = 4'b1110;
        imm  = {{20{sx}}, instr[31:25], instr[11:7]};
      end
      TYPE_SB: begin
        uses = 4'b1110;
        imm  = {{19{sx}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      TYPE_U: begin
        uses = 4'b1001;
        imm  = {instr[31:12], 12'd0};
      end
      TYPE_UJ: begin
        uses = 4'b1001;
        imm  = {{11{sx}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      default: begin // TYPE_NONE
        uses = 4'b0000;
        imm  = '0;
      end
    endcase
  end

  // Incoming low nibble acts as a mask for the odd cases
  assign flag[3:0] = in_flag[`FLAG_IS_DIFF] ? (uses & in_flag[3:0]) : uses;
  assign flag[7:4] = in_flag[7:4];

endmodule

//--- design/rv_reg_name.sv
`timescale 1ns/1ns

module rv_reg_name import rv_pkg::*; (
  input  reg_idx_t  reg_number,
  output reg_name_t reg_name
);

  // ABI names indexed by register number
  localparam reg_name_t ABI_NAME [32] = '{
    "zero", "ra  ", "sp  ", "gp  ",
    "tp  ", "t0  ", "t1  ", "t2  ",
    "s0  ", "s1  ", "a0  ", "a1  ",
    "a2  ", "a3  ", "a4  ", "a5  ",
    "a6  ", "a7  ", "s2  ", "s3  ",
    "s4  ", "s5  ", "s6  ", "s7  ",
    "s8  ", "s9  ", "s10 ", "s11 ",
    "t3  ", "t4  ", "t5  ", "t6  "
  };

  assign reg_name = ABI_NAME[reg_number];

endmodule

//--- design/rv_pkg.sv
package rv_pkg;

  `include "rv_opcodes.svh"

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [31:0] reg_name_t; // Four ASCII chars, space padded
  typedef logic [2:0]  instr_type_t;
  typedef logic [3:0]  alu_op_t;
  typedef logic [7:0]  flag_t;

  // Instruction formats
  localparam instr_type_t TYPE_R    = 3'd0;
  localparam instr_type_t TYPE_I    = 3'd1;
  localparam instr_type_t TYPE_S    = 3'd2;
  localparam instr_type_t TYPE_SB   = 3'd3;
  localparam instr_type_t TYPE_U    = 3'd4;
  localparam instr_type_t TYPE_UJ   = 3'd5;
  localparam instr_type_t TYPE_NONE = 3'd6;

  localparam alu_op_t ALU_ADD    = 4'd0;
  localparam alu_op_t ALU_SUB    = 4'd1;
  localparam alu_op_t ALU_SLL    = 4'd2;
  localparam alu_op_t ALU_SLT    = 4'd3;
  localparam alu_op_t ALU_SLTU   = 4'd4;
  localparam alu_op_t ALU_XOR    = 4'd5;
  localparam alu_op_t ALU_SRL    = 4'd6;
  localparam alu_op_t ALU_SRA    = 4'd7;
  localparam alu_op_t ALU_OR     = 4'd8;
  localparam alu_op_t ALU_AND    = 4'd9;
  localparam alu_op_t ALU_PASS_B = 4'd10;
  localparam alu_op_t ALU_PC_ADD = 4'd11; // Link value pc+4

  typedef struct packed {
    logic        valid;
    word_t       pc;
    instr_type_t instr_type;
    alu_op_t     alu_op;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    word_t       imm;
    flag_t       flags;
    reg_name_t   rd_name;
    reg_name_t   rs1_name;
    reg_name_t   rs2_name;
  } decoded_t;

  typedef struct packed {
    logic      valid;
    word_t     pc;
    reg_idx_t  rd;
    logic      wr_en;
    word_t     data;
    logic      br_taken;
    word_t     target;
    word_t     store_addr;
    word_t     store_data;
    logic      illegal;
    reg_name_t rd_name;
    reg_name_t rs1_name;
    reg_name_t rs2_name;
  } result_t;

endpackage

//--- include/rv_opcodes.svh
`ifndef RV_OPCODES_SVH
`define RV_OPCODES_SVH

// RV32I major opcodes
`define OPC_LUI      7'b0110111
`define OPC_AUIPC    7'b0010111
`define OPC_JAL      7'b1101111
`define OPC_JALR     7'b1100111
`define OPC_BRANCH   7'b1100011
`define OPC_LOAD     7'b0000011
`define OPC_STORE    7'b0100011
`define OPC_OP_IMM   7'b0010011
`define OPC_OP       7'b0110011
`define OPC_MISC_MEM 7'b0001111
`define OPC_SYSTEM   7'b1110011

// ALU funct3
`define F3_ADD_SUB 3'b000
`define F3_SLL     3'b001
`define F3_SLT     3'b010
`define F3_SLTU    3'b011
`define F3_XOR     3'b100
`define F3_SRL_SRA 3'b101
`define F3_OR      3'b110
`define F3_AND     3'b111

// Branch funct3
`define F3_BEQ  3'b000
`define F3_BNE  3'b001
`define F3_BLT  3'b100
`define F3_BGE  3'b101
`define F3_BLTU 3'b110
`define F3_BGEU 3'b111

// Bit positions inside flag_t
`define FLAG_USES_RD   0
`define FLAG_USES_RS1  1
`define FLAG_USES_RS2  2
`define FLAG_USES_IMM  3
`define FLAG_IS_CTRL   4
`define FLAG_IS_SIGNED 5
`define FLAG_IS_DIFF   6
`define FLAG_IS_STORE  7

`endif
